//--- rtl/vpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions of the vector thread.
// Widths, the host address map, register index and response
// enums, the operand descriptor and register file bundles,
// and the AXI4-Lite request and response bundles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vpu_pkg;

	localparam int AXI_AW   = 16;			// Host address width.
	localparam int AXI_DW   = 32;			// Host data width.
	localparam int ACC_W    = 32;			// Accumulator.
	localparam int VL_W     = 20;			// Vector length.
	localparam int STRIDE_W = 6;			// Signed element stride.
	localparam int ADDR_W   = 32;			// Element address.
	localparam int OPND_W   = STRIDE_W + ADDR_W;	// Full descriptor.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host address map.
	localparam logic [AXI_AW-1:0] REG_BASE     = 16'h0000;	// Registers at 4*index.
	localparam logic [AXI_AW-1:0] OPND_HI_ADDR = 16'h0018;	// Stride staging word.
	localparam logic [AXI_AW-1:0] SPAD_BASE    = 16'h1000;	// Scratchpad window.

	typedef enum logic [2:0] {
		IDX_ACC = 3'd0,		// Accumulator.
		IDX_VL  = 3'd1,		// Vector length.
		IDX_EN  = 3'd2,		// Thread enable.
		IDX_RS  = 3'd3,		// Source 1.
		IDX_RT  = 3'd4,		// Source 2.
		IDX_RD  = 3'd5		// Destination.
	} vpu_reg_idx_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} vpu_resp_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register file bundles.
	typedef struct packed {
		logic signed [STRIDE_W-1:0] stride;	// Step in elements.
		logic [ADDR_W-1:0]          addr;	// First element.
	} vpu_opnd_t;

	typedef struct packed {
		vpu_reg_idx_e      idx;
		logic              wr_en;
		logic [OPND_W-1:0] data;		// Low bits for narrow registers.
	} vpu_rf_wr_t;

	typedef struct packed {
		logic [ACC_W-1:0] acc;
		logic [VL_W-1:0]  vl;
		logic             en;
		vpu_opnd_t        rs;
		vpu_opnd_t        rt;
		vpu_opnd_t        rd;
	} vpu_thread_regs_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI4-Lite channels.
	typedef struct packed {
		logic [AXI_AW-1:0] awaddr;
		logic              awvalid;
		logic [AXI_DW-1:0] wdata;
		logic [3:0]        wstrb;
		logic              wvalid;
		logic              bready;
		logic [AXI_AW-1:0] araddr;
		logic              arvalid;
		logic              rready;
	} vpu_axil_req_t;

	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              bvalid;
		vpu_resp_e         bresp;
		logic              arready;
		logic              rvalid;
		logic [AXI_DW-1:0] rdata;
		vpu_resp_e         rresp;
	} vpu_axil_rsp_t;

endpackage

//--- rtl/vpu_thread_rf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Thread register file.
// Index decode into per-register write enables and the six
// thread registers, presented as one bundle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module vpu_thread_rf (
	input  logic                      clk,
	input  logic                      rst_n,
	input  vpu_pkg::vpu_rf_wr_t       wr,	// Single write port.
	output vpu_pkg::vpu_thread_regs_t regs	// All register values.
);
	import vpu_pkg::*;

	logic acc_we;
	logic vl_we;
	logic en_we;
	logic rs_we;
	logic rt_we;
	logic rd_we;

	logic [ACC_W-1:0] acc_q;
	logic [VL_W-1:0]  vl_q;
	logic             en_q;
	vpu_opnd_t        rs_q;
	vpu_opnd_t        rt_q;
	vpu_opnd_t        rd_q;

	// Index decode.
	always_comb begin
		acc_we = 1'b0;
		vl_we  = 1'b0;
		en_we  = 1'b0;
		rs_we  = 1'b0;
		rt_we  = 1'b0;
		rd_we  = 1'b0;
		case (wr.idx)
			IDX_ACC: acc_we = wr.wr_en;
			IDX_VL:  vl_we  = wr.wr_en;
			IDX_EN:  en_we  = wr.wr_en;
			IDX_RS:  rs_we  = wr.wr_en;
			IDX_RT:  rt_we  = wr.wr_en;
			IDX_RD:  rd_we  = wr.wr_en;
			default: ;			// Unused codes write nothing.
		endcase
	end

	// Enable is the only register with a reset.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_q <= 1'b0;			// Thread idle out of reset.
		end else if (en_we) begin
			en_q <= wr.data[0];
		end
	end

	always_ff @(posedge clk) begin
		if (acc_we) begin
			acc_q <= wr.data[ACC_W-1:0];
		end
		if (vl_we) begin
			vl_q <= wr.data[VL_W-1:0];	// Upper bits dropped.
		end
		if (rs_we) begin
			rs_q <= wr.data;		// Stride and address.
		end
		if (rt_we) begin
			rt_q <= wr.data;
		end
		if (rd_we) begin
			rd_q <= wr.data;
		end
	end

	assign regs = '{acc: acc_q, vl: vl_q, en: en_q, rs: rs_q, rt: rt_q, rd: rd_q};

	// The slave merges host and result writes, so check what reaches the port.
	a_wr_legal: assert property (@(posedge clk) disable iff (!rst_n)
		wr.wr_en |-> (wr.idx <= IDX_RD));

endmodule

//--- rtl/vpu_axil_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave of the vector thread.
// Address decode, descriptor stride staging, busy rejection,
// the two-cycle read pipeline, scratchpad port a access and
// the merged register file write port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module vpu_axil_regs #(
	parameter int SPAD_AW = 8
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  vpu_pkg::vpu_axil_req_t    axil_req,
	output vpu_pkg::vpu_axil_rsp_t    axil_rsp,
	input  vpu_pkg::vpu_thread_regs_t regs,
	output vpu_pkg::vpu_rf_wr_t       rf_wr,
	input  logic                      res_valid,	// Result strobe from the thread.
	input  logic [31:0]               res_data,
	output logic [3:0]                spad_we,
	output logic [SPAD_AW-1:0]        spad_addr,
	output logic [31:0]               spad_wdata,
	input  logic [31:0]               spad_rdata
);
	import vpu_pkg::*;

	logic              aw_hs;		// Write accepted this cycle.
	logic              ar_hs;		// Read accepted this cycle.
	logic              wr_ok;
	logic              wr_ok_q;		// Commit cycle.
	logic              spad_wr_now;
	logic              spad_wr_next;
	logic              rd_busy_next;
	logic              bvalid_q;
	logic              rd_s1_q;		// Read pipeline stage one.
	logic              rvalid_q;
	logic              arready_q;
	logic              clr_en_q;	// EN clear after a result.
	vpu_resp_e         bresp_q;
	vpu_resp_e         rresp_q;
	vpu_resp_e         rd_resp_d;
	logic [AXI_AW-1:0] wr_addr_q;
	logic [AXI_AW-1:0] rd_addr_q;
	logic [AXI_AW-1:0] wr_off;
	logic [AXI_AW-1:0] rd_off;
	logic [AXI_DW-1:0] wr_data_q;
	logic [AXI_DW-1:0] rdata_q;
	logic [AXI_DW-1:0] rd_data_d;
	logic [3:0]        wr_strb_q;
	logic [STRIDE_W-1:0] stage_q;	// Stride for the next descriptor.

	function automatic logic dec_reg(input logic [AXI_AW-1:0] a);
		logic [AXI_AW-1:0] off;
		off = a - REG_BASE;
		return (off[AXI_AW-1:5] == '0) && (off[4:2] <= 3'(IDX_RD));
	endfunction

	function automatic logic dec_stage(input logic [AXI_AW-1:0] a);
		return a[AXI_AW-1:2] == OPND_HI_ADDR[AXI_AW-1:2];
	endfunction

	function automatic logic dec_spad(input logic [AXI_AW-1:0] a);
		return a[AXI_AW-1:12] == SPAD_BASE[AXI_AW-1:12];	// 4 KB window, aliased.
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write channel.
	assign aw_hs = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
	assign wr_ok = ~regs.en & (dec_reg(axil_req.awaddr) | dec_stage(axil_req.awaddr)
		| dec_spad(axil_req.awaddr));			// Busy thread rejects all.
	assign wr_off = wr_addr_q - REG_BASE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid_q <= 1'b0;
			bresp_q  <= RESP_OKAY;
			wr_ok_q  <= 1'b0;
			clr_en_q <= 1'b0;
		end else begin
			wr_ok_q  <= aw_hs & wr_ok;
			clr_en_q <= res_valid;		// EN write one cycle after ACC.
			if (aw_hs) begin
				bvalid_q <= 1'b1;
				bresp_q  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			end else if (axil_req.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	// Register file port. Result writes win, host writes never overlap them.
	always_comb begin
		rf_wr.idx   = vpu_reg_idx_e'(wr_off[4:2]);
		rf_wr.wr_en = wr_ok_q & dec_reg(wr_addr_q);
		rf_wr.data  = {stage_q, wr_data_q};	// Narrow registers take low bits.
		if (res_valid) begin
			rf_wr.idx   = IDX_ACC;
			rf_wr.wr_en = 1'b1;
			rf_wr.data  = {{STRIDE_W{1'b0}}, res_data};
		end else if (clr_en_q) begin
			rf_wr.idx   = IDX_EN;
			rf_wr.wr_en = 1'b1;
			rf_wr.data  = '0;			// Thread back to idle.
		end
	end

	// Scratchpad port a. A commit owns the port and holds reads off.
	assign spad_wr_now = wr_ok_q & dec_spad(wr_addr_q);
	assign spad_we     = spad_wr_now ? wr_strb_q : 4'b0000;
	assign spad_addr   = spad_wr_now ? wr_addr_q[SPAD_AW+1:2] : axil_req.araddr[SPAD_AW+1:2];
	assign spad_wdata  = wr_data_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read channel.
	assign ar_hs        = axil_req.arvalid & arready_q;
	assign spad_wr_next = aw_hs & wr_ok & dec_spad(axil_req.awaddr);
	assign rd_busy_next = ar_hs | rd_s1_q | (rvalid_q & ~axil_req.rready);
	assign rd_off       = rd_addr_q - REG_BASE;

	always_comb begin
		rd_data_d = '0;
		rd_resp_d = RESP_OKAY;
		if (dec_spad(rd_addr_q)) begin
			rd_data_d = spad_rdata;			// Issued in the accept cycle.
		end else if (dec_stage(rd_addr_q)) begin
			rd_data_d = {{(AXI_DW-STRIDE_W){1'b0}}, stage_q};
		end else if (dec_reg(rd_addr_q)) begin
			case (vpu_reg_idx_e'(rd_off[4:2]))
				IDX_ACC: rd_data_d = regs.acc;
				IDX_VL:  rd_data_d = {{(AXI_DW-VL_W){1'b0}}, regs.vl};
				IDX_EN:  rd_data_d = {{(AXI_DW-1){1'b0}}, regs.en};
				IDX_RS:  rd_data_d = regs.rs.addr;
				IDX_RT:  rd_data_d = regs.rt.addr;
				IDX_RD:  rd_data_d = regs.rd.addr;
				default: rd_data_d = '0;
			endcase
		end else begin
			rd_resp_d = RESP_SLVERR;		// Unmapped reads return zero.
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready_q <= 1'b0;
			rd_s1_q   <= 1'b0;
			rvalid_q  <= 1'b0;
			rresp_q   <= RESP_OKAY;
		end else begin
			arready_q <= ~rd_busy_next & ~spad_wr_next;
			rd_s1_q   <= ar_hs;
			if (rd_s1_q) begin
				rvalid_q <= 1'b1;		// Two cycles after accept.
				rresp_q  <= rd_resp_d;
			end else if (axil_req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// Payload registers.
	always_ff @(posedge clk) begin
		if (aw_hs) begin
			wr_addr_q <= axil_req.awaddr;
			wr_data_q <= axil_req.wdata;
			wr_strb_q <= axil_req.wstrb;
		end
		if (ar_hs) begin
			rd_addr_q <= axil_req.araddr;
		end
		if (rd_s1_q) begin
			rdata_q <= rd_data_d;
		end
		if (wr_ok_q && dec_stage(wr_addr_q)) begin
			stage_q <= wr_data_q[STRIDE_W-1:0];	// Strobes ignored.
		end
	end

	always_comb begin
		axil_rsp.awready = aw_hs;
		axil_rsp.wready  = aw_hs;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.arready = arready_q;
		axil_rsp.rvalid  = rvalid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
	end

	a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q));

endmodule

//--- rtl/vpu_scratchpad.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Thread scratchpad.
// True dual-port word memory, byte strobes on port a, whole
// words on port b, registered reads on both.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module vpu_scratchpad #(
	parameter int SPAD_AW = 8
) (
	input  logic               clk,
	input  logic [3:0]         a_we,	// Host port, per byte.
	input  logic [SPAD_AW-1:0] a_addr,
	input  logic [31:0]        a_wdata,
	output logic [31:0]        a_rdata,
	input  logic               b_we,	// Thread port, whole word.
	input  logic [SPAD_AW-1:0] b_addr,
	input  logic [31:0]        b_wdata,
	output logic [31:0]        b_rdata
);
	localparam int DEPTH = 1 << SPAD_AW;

	logic [31:0] mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (a_we[i]) begin
				mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
			end
		end
		if (b_we) begin
			mem[b_addr] <= b_wdata;	// Ports never write while both active.
		end
		a_rdata <= mem[a_addr];		// Old data on a same-cycle write.
		b_rdata <= mem[b_addr];
	end

endmodule

//--- rtl/vpu_thread_exec.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Thread execution unit.
// Dot-product FSM over two strided source vectors, with the
// result stored to the destination and handed back to ACC.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module vpu_thread_exec #(
	parameter int SPAD_AW = 8
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  vpu_pkg::vpu_thread_regs_t regs,
	output logic                      mem_we,
	output logic [SPAD_AW-1:0]        mem_addr,
	output logic [31:0]               mem_wdata,
	input  logic [31:0]               mem_rdata,
	output logic                      res_valid,	// ACC update strobe.
	output logic [31:0]               res_data,
	output logic                      done
);
	typedef enum logic [2:0] {
		IDLE,
		READ_S,		// Issue source 1 read.
		READ_T,		// Issue source 2 read, catch source 1.
		MAC,		// Multiply-accumulate and step.
		STORE,		// Write sum to destination.
		FINISH		// Result strobe and done.
	} state_e;

	state_e             state;
	logic               done_q;		// EN still high right after FINISH.
	logic [19:0]        cnt;		// Elements left.
	logic [SPAD_AW-1:0] s_ptr;
	logic [SPAD_AW-1:0] t_ptr;
	logic [31:0]        s_val;
	logic [31:0]        sum;
	logic [31:0]        prod;
	logic [31:0]        s_step;
	logic [31:0]        t_step;

	assign s_step = {{26{regs.rs.stride[5]}}, regs.rs.stride};	// Sign extend.
	assign t_step = {{26{regs.rt.stride[5]}}, regs.rt.stride};
	assign prod   = s_val * mem_rdata;				// Low 32 bits.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= IDLE;
			done_q <= 1'b0;
			sum    <= '0;
		end else begin
			done_q <= (state == FINISH);
			case (state)
				IDLE: begin
					if (regs.en && !done_q) begin
						sum   <= regs.acc;	// Start from ACC.
						state <= (regs.vl == '0) ? STORE : READ_S;
					end
				end
				READ_S: state <= READ_T;
				READ_T: state <= MAC;
				MAC: begin
					sum   <= sum + prod;
					state <= (cnt == 20'd1) ? STORE : READ_S;
				end
				STORE:   state <= FINISH;
				FINISH:  state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Datapath.
	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				cnt   <= regs.vl;
				s_ptr <= regs.rs.addr[SPAD_AW-1:0];	// Index wraps at depth.
				t_ptr <= regs.rt.addr[SPAD_AW-1:0];
			end
			READ_T: s_val <= mem_rdata;
			MAC: begin
				cnt   <= cnt - 20'd1;
				s_ptr <= s_ptr + s_step[SPAD_AW-1:0];
				t_ptr <= t_ptr + t_step[SPAD_AW-1:0];
			end
			default: ;
		endcase
	end

	always_comb begin
		case (state)
			READ_T:  mem_addr = t_ptr;
			STORE:   mem_addr = regs.rd.addr[SPAD_AW-1:0];
			default: mem_addr = s_ptr;
		endcase
	end

	assign mem_we    = (state == STORE);
	assign mem_wdata = sum;
	assign res_valid = (state == FINISH);
	assign res_data  = sum;
	assign done      = (state == FINISH);

	// Host cannot drop EN under a running thread.
	a_en_held: assert property (@(posedge clk) disable iff (!rst_n)
		(state != IDLE) |-> regs.en);

endmodule

//--- rtl/vpu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector thread top level.
// AXI4-Lite slave, register file, scratchpad and execution
// unit. Port a of the scratchpad is the host side.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module vpu_top #(
	parameter int SPAD_AW = 8		// Scratchpad holds 2^SPAD_AW words.
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  vpu_pkg::vpu_axil_req_t axil_req,
	output vpu_pkg::vpu_axil_rsp_t axil_rsp,
	output logic                   done
);
	import vpu_pkg::*;

	vpu_thread_regs_t   regs;
	vpu_rf_wr_t         rf_wr;
	logic               res_valid;
	logic [31:0]        res_data;
	logic [3:0]         spad_a_we;	// Host side.
	logic [SPAD_AW-1:0] spad_a_addr;
	logic [31:0]        spad_a_wdata;
	logic [31:0]        spad_a_rdata;
	logic               spad_b_we;	// Thread side.
	logic [SPAD_AW-1:0] spad_b_addr;
	logic [31:0]        spad_b_wdata;
	logic [31:0]        spad_b_rdata;

	vpu_axil_regs #(.SPAD_AW(SPAD_AW)) regs0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.regs       (regs),
		.rf_wr      (rf_wr),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.spad_we    (spad_a_we),
		.spad_addr  (spad_a_addr),
		.spad_wdata (spad_a_wdata),
		.spad_rdata (spad_a_rdata)
	);

	vpu_thread_rf rf0 (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (rf_wr),
		.regs  (regs)
	);

	vpu_scratchpad #(.SPAD_AW(SPAD_AW)) spad0 (
		.clk     (clk),
		.a_we    (spad_a_we),
		.a_addr  (spad_a_addr),
		.a_wdata (spad_a_wdata),
		.a_rdata (spad_a_rdata),
		.b_we    (spad_b_we),
		.b_addr  (spad_b_addr),
		.b_wdata (spad_b_wdata),
		.b_rdata (spad_b_rdata)
	);

	vpu_thread_exec #(.SPAD_AW(SPAD_AW)) exec0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.regs      (regs),
		.mem_we    (spad_b_we),
		.mem_addr  (spad_b_addr),
		.mem_wdata (spad_b_wdata),
		.mem_rdata (spad_b_rdata),
		.res_valid (res_valid),
		.res_data  (res_data),
		.done      (done)
	);

endmodule

//--- dv/tb_clkgen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset.
// 4 ns clock, rst_n low for the first 3 cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_clkgen (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;			// Held through 3 edges.
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	end

	always #2 clk = ~clk;		// 4 ns period.

endmodule

//--- dv/vpu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector thread testbench.
// AXI4-Lite host tasks, scratchpad model, dot-product
// reference, compare tasks and the six tests.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module vpu_tb;
	import vpu_pkg::*;

	localparam int TMO = 200;		// Cycles per wait loop.

	logic          clk;
	logic          rst_n;
	logic          done;
	vpu_axil_req_t req;
	vpu_axil_rsp_t rsp;
	integer        seed;
	int            checks;
	int            errors;
	int            test_err0;
	bit            bp_on;			// Random back-pressure.
	logic [31:0]   spad_model [0:255];

	tb_clkgen clkgen0 (.clk(clk), .rst_n(rst_n));

	vpu_top #(.SPAD_AW(8)) dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.axil_req (req),
		.axil_rsp (rsp),
		.done     (done)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Compare and report.
	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_resp(input string name, input vpu_resp_e got, input vpu_resp_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s finished with %0d errors", num, name, errors - test_err0);
		test_err0 = errors;
	endtask

	function automatic logic [15:0] reg_addr(input vpu_reg_idx_e i);
		return REG_BASE + {11'd0, i, 2'b00};
	endfunction

	function automatic logic [15:0] spad_addr(input int k);
		return SPAD_BASE + 16'(4 * k);		// k past 255 aliases.
	endfunction

	function automatic logic [31:0] fill_word(input logic [7:0] i);
		return {i ^ 8'hc3, i, ~i, i + 8'h11};
	endfunction

	// Strided dot product over the model, indices mod 256.
	function automatic logic [31:0] dot_ref(input logic [31:0] acc, input int vl,
			input logic [31:0] sa, input logic signed [5:0] ss,
			input logic [31:0] ta, input logic signed [5:0] ts);
		logic [31:0] sum;
		int          si;
		int          ti;
		sum = acc;
		for (int i = 0; i < vl; i++) begin
			si  = (int'(sa) + i * int'(ss)) & 255;
			ti  = (int'(ta) + i * int'(ts)) & 255;
			sum = sum + spad_model[si] * spad_model[ti];	// Low 32 bits.
		end
		return sum;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI4-Lite host. Drive on negedge, sample 1 ns later.
	task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output vpu_resp_e resp);
		int n;
		int hold;
		hold = bp_on ? ($random(seed) & 7) : 0;
		@(negedge clk);
		req.awaddr  = addr;
		req.wdata   = data;
		req.wstrb   = strb;
		req.awvalid = 1'b1;
		req.wvalid  = 1'b1;
		n = 0;
		#1;
		while (!(rsp.awready || rsp.wready)) begin
			if (++n > TMO) abort_on_timeout("awready");
			@(negedge clk);
			#1;
		end
		check_word("awready", {31'd0, rsp.awready}, 32'd1);	// Both rise together.
		check_word("wready", {31'd0, rsp.wready}, 32'd1);
		@(negedge clk);
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		n = 0;
		#1;
		while (!rsp.bvalid) begin
			if (++n > TMO) abort_on_timeout("bvalid");
			@(negedge clk);
			#1;
		end
		resp = rsp.bresp;
		for (int k = 0; k < hold; k++) begin
			@(negedge clk);
			#1;
			if (!rsp.bvalid) begin
				errors++;
				$display("bvalid dropped while bready was low");
			end
			check_resp("bresp held", rsp.bresp, resp);
		end
		@(negedge clk);
		req.bready = 1'b1;
		@(negedge clk);
		req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
			output vpu_resp_e resp);
		int n;
		int hold;
		hold = bp_on ? ($random(seed) & 7) : 0;
		@(negedge clk);
		req.araddr  = addr;
		req.arvalid = 1'b1;
		n = 0;
		#1;
		while (!rsp.arready) begin
			if (++n > TMO) abort_on_timeout("arready");
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		req.arvalid = 1'b0;
		n = 0;
		#1;
		while (!rsp.rvalid) begin
			if (++n > TMO) abort_on_timeout("rvalid");
			@(negedge clk);
			#1;
		end
		data = rsp.rdata;
		resp = rsp.rresp;
		for (int k = 0; k < hold; k++) begin
			@(negedge clk);
			#1;
			if (!rsp.rvalid) begin
				errors++;
				$display("rvalid dropped while rready was low");
			end
			check_word("rdata held", rsp.rdata, data);
			check_resp("rresp held", rsp.rresp, resp);
		end
		@(negedge clk);
		req.rready = 1'b1;
		@(negedge clk);
		req.rready = 1'b0;
	endtask

	task automatic write_expect(input logic [15:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input vpu_resp_e exp);
		vpu_resp_e r;
		axi_write(addr, data, strb, r);
		check_resp($sformatf("bresp @%h", addr), r, exp);
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp,
			input vpu_resp_e exp_resp);
		logic [31:0] d;
		vpu_resp_e   r;
		axi_read(addr, d, r);
		check_resp($sformatf("rresp @%h", addr), r, exp_resp);
		check_word($sformatf("rdata @%h", addr), d, exp);
	endtask

	task automatic set_opnd(input vpu_reg_idx_e idx, input logic [31:0] a,
			input logic signed [5:0] s);
		write_expect(OPND_HI_ADDR, {26'd0, s}, 4'hf, RESP_OKAY);	// Stride first.
		write_expect(reg_addr(idx), a, 4'hf, RESP_OKAY);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Thread sequences.
	task automatic program_thread(input logic [31:0] acc, input int vl,
			output logic [31:0] exp, output logic [31:0] rd_a);
		logic [31:0]        sa;
		logic [31:0]        ta;
		logic signed [5:0]  ss;
		logic signed [5:0]  ts;
		sa   = $random(seed);
		ta   = $random(seed);
		rd_a = $random(seed);
		ss   = 6'($random(seed));		// Either sign.
		ts   = 6'($random(seed));
		write_expect(reg_addr(IDX_ACC), acc, 4'hf, RESP_OKAY);
		write_expect(reg_addr(IDX_VL), 32'(vl), 4'hf, RESP_OKAY);
		set_opnd(IDX_RS, sa, ss);
		set_opnd(IDX_RT, ta, ts);
		set_opnd(IDX_RD, rd_a, 6'sd0);
		exp = dot_ref(acc, vl, sa, ss, ta, ts);
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge clk);
		#1;
		while (!done) begin
			if (++n > TMO) abort_on_timeout("done");
			@(negedge clk);
			#1;
		end
	endtask

	task automatic check_result(input logic [31:0] exp, input logic [31:0] rd_a);
		read_expect(reg_addr(IDX_EN), 32'd0, RESP_OKAY);
		read_expect(reg_addr(IDX_ACC), exp, RESP_OKAY);
		read_expect(spad_addr(int'(rd_a[7:0])), exp, RESP_OKAY);
		spad_model[rd_a[7:0]] = exp;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests.
	initial begin
		logic [31:0] v;
		logic [31:0] exp;
		logic [31:0] rd_a;
		logic [3:0]  strb;
		logic [31:0] d;
		vpu_resp_e   r;
		int          k;
		int          n;
		seed      = 32'h707b206e;
		req       = '0;
		checks    = 0;
		errors    = 0;
		test_err0 = 0;
		bp_on     = 1'b0;
		n = 0;
		while (rst_n !== 1'b1) begin
			if (++n > TMO) abort_on_timeout("reset release");
			@(negedge clk);
		end

		// 1. Register access.
		read_expect(reg_addr(IDX_EN), 32'd0, RESP_OKAY);
		v = $random(seed);
		write_expect(reg_addr(IDX_ACC), v, 4'h1, RESP_OKAY);	// Strobes ignored.
		read_expect(reg_addr(IDX_ACC), v, RESP_OKAY);
		v = $random(seed);
		write_expect(reg_addr(IDX_VL), v, 4'hf, RESP_OKAY);
		read_expect(reg_addr(IDX_VL), v & 32'h000f_ffff, RESP_OKAY);
		write_expect(reg_addr(IDX_EN), 32'hffff_fffe, 4'hf, RESP_OKAY);
		read_expect(reg_addr(IDX_EN), 32'd0, RESP_OKAY);
		v = $random(seed);
		write_expect(OPND_HI_ADDR, v, 4'hf, RESP_OKAY);
		read_expect(OPND_HI_ADDR, v & 32'h3f, RESP_OKAY);
		for (int i = 3; i <= 5; i++) begin
			v = $random(seed);
			write_expect(reg_addr(vpu_reg_idx_e'(i)), v, 4'hf, RESP_OKAY);
			read_expect(reg_addr(vpu_reg_idx_e'(i)), v, RESP_OKAY);
		end
		end_test(1, "registers");

		// 2. Scratchpad fill, strobe merges, aliased window.
		for (int i = 0; i < 256; i++) begin
			spad_model[i] = fill_word(8'(i));
			write_expect(spad_addr(i), spad_model[i], 4'hf, RESP_OKAY);
		end
		for (int i = 0; i < 24; i++) begin
			k    = $random(seed) & 511;			// Half the hits alias.
			v    = $random(seed);
			strb = 4'($random(seed));
			write_expect(spad_addr(k), v, strb, RESP_OKAY);
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) spad_model[k & 255][8*b +: 8] = v[8*b +: 8];
			end
			read_expect(spad_addr(k ^ 256), spad_model[k & 255], RESP_OKAY);
		end
		end_test(2, "scratchpad");

		// 3. Random dot products.
		for (int t = 0; t < 8; t++) begin
			program_thread($random(seed), 1 + (($random(seed) & 32'h7fff_ffff) % 20),
				exp, rd_a);
			write_expect(reg_addr(IDX_EN), 32'd1, 4'hf, RESP_OKAY);
			wait_done();
			check_result(exp, rd_a);
		end
		end_test(3, "dot product");

		// 4. Zero length.
		v = $random(seed);
		program_thread(v, 0, exp, rd_a);
		write_expect(reg_addr(IDX_EN), 32'd1, 4'hf, RESP_OKAY);
		wait_done();
		check_result(v, rd_a);
		end_test(4, "zero length");

		// 5. Busy rejection and unmapped addresses.
		program_thread($random(seed), 20, exp, rd_a);
		write_expect(reg_addr(IDX_EN), 32'd1, 4'hf, RESP_OKAY);
		write_expect(reg_addr(IDX_ACC), 32'h1234_5678, 4'hf, RESP_SLVERR);
		write_expect(spad_addr(int'(rd_a[7:0]) ^ 1), 32'hdead_beef, 4'hf, RESP_SLVERR);
		write_expect(reg_addr(IDX_EN), 32'd0, 4'hf, RESP_SLVERR);
		read_expect(reg_addr(IDX_VL), 32'd20, RESP_OKAY);
		read_expect(16'h0020, 32'd0, RESP_SLVERR);
		write_expect(16'h0800, 32'h5555_aaaa, 4'hf, RESP_SLVERR);
		n = 0;
		d = 32'd1;
		while (d != 32'd0) begin
			if (++n > TMO) abort_on_timeout("EN to clear");
			axi_read(reg_addr(IDX_EN), d, r);
			check_resp("rresp EN poll", r, RESP_OKAY);
		end
		check_result(exp, rd_a);
		read_expect(spad_addr(int'(rd_a[7:0]) ^ 1), spad_model[rd_a[7:0] ^ 8'd1], RESP_OKAY);
		read_expect(16'h2000, 32'd0, RESP_SLVERR);
		write_expect(16'h0040, 32'd7, 4'hf, RESP_SLVERR);
		end_test(5, "busy and unmapped");

		// 6. Random back-pressure on B and R.
		bp_on = 1'b1;
		for (int i = 0; i < 16; i++) begin
			k = $random(seed) & 255;
			v = $random(seed);
			write_expect(spad_addr(k), v, 4'hf, RESP_OKAY);
			spad_model[k] = v;
			write_expect(reg_addr(IDX_ACC), ~v, 4'hf, RESP_OKAY);
			read_expect(reg_addr(IDX_ACC), ~v, RESP_OKAY);
			read_expect(spad_addr(k), spad_model[k], RESP_OKAY);
			read_expect(16'h0030, 32'd0, RESP_SLVERR);
		end
		bp_on = 1'b0;
		end_test(6, "back-pressure");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- project.f
rtl/vpu_pkg.sv
rtl/vpu_thread_rf.sv
rtl/vpu_axil_regs.sv
rtl/vpu_scratchpad.sv
rtl/vpu_thread_exec.sv
rtl/vpu_top.sv
dv/tb_clkgen.sv
dv/vpu_tb.sv

//--- run.sh
#!/bin/sh
# Build the vector thread testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module vpu_tb -o vpu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/vpu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
	exit 0
fi
exit 1
